//--- sources.f
dcache_pkg.sv
dcache_arrays.sv
dcache_plru.sv
dcache_datapath.sv
dcache_ctrl.sv
dcache_top.sv
dcache_asserts.sv
tb_dcache.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_dcache
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Regression failed
PASS_MSG = Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_dcache.sv
/* dcache testbench
   random loads and stores against a word model, random-latency line memory */
`timescale 1ns/1ps
module tb_dcache;
    localparam int n_req       = 2000;
    localparam int clk_period  = 8;
    localparam int miss_cycles = 32;                // write-back plus refill at the longest delays
    localparam int timeout_ns  = (n_req + 10) * miss_cycles * clk_period;
    localparam logic [23:0] tag_base = 24'h0c0000; // 8 tags in the low 3 bits

    logic clk, rst_n, req_valid, req_write;
    dcache_pkg::addr_u req_addr;
    logic [3:0] req_wstrb;
    logic [31:0] req_wdata, rdata, rd_addr, wr_addr;
    dcache_pkg::load_type_e load_type;
    logic busy, rd_req, rd_rdy, ret_valid, wr_req, wr_rdy, wr_valid;
    dcache_pkg::line_t ret_data, wr_data;

    logic [31:0] golden [512];   // processor view as of store acceptance
    logic [31:0] backing [512];  // memory behind the cache
    logic cur_valid, cur_write, last_was_store;
    logic [31:0] cur_addr, last_store_addr;
    dcache_pkg::load_type_e cur_lt;
    int err_count, check_count, load_count, store_count;

    dcache_top i_dut (
        .clk, .rst_n, .req_valid, .req_write, .req_addr, .req_wstrb, .req_wdata, .load_type,
        .busy, .rdata, .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy, .wr_valid
    );

    bind dcache_ctrl dcache_asserts i_asserts (
        .clk, .rst_n, .busy, .req_valid, .rd_req, .rd_rdy, .wr_req, .wr_rdy, .state
    );

    function automatic logic [31:0] fill_word(logic [31:0] a);
        return (a * 32'h9e3779b1) ^ 32'h3c6ef372;
    endfunction

    function automatic int word_slot(logic [31:0] a);
        return int'(a[10:2]);
    endfunction

    function automatic logic [31:0] make_addr(int t, int idx, int off);
        logic [23:0] tag;
        tag = tag_base | 24'(t);
        return {tag, 4'(idx), 4'(off)};
    endfunction

    function automatic dcache_pkg::line_t read_line(input logic [31:0] mem [512],
                                                    input logic [31:0] a);
        dcache_pkg::line_t l;
        for (int w = 0; w < 4; w++) l[w] = mem[word_slot({a[31:4], 4'h0}) + w];
        return l;
    endfunction

    // shift the addressed byte or half down before extending
    function automatic logic [31:0] expect_load(logic [31:0] w, dcache_pkg::load_type_e lt,
                                                logic [1:0] off);
        logic [31:0] sh;
        sh = w >> (8 * off);
        case (lt)
            dcache_pkg::lh:  return {{16{sh[15]}}, sh[15:0]};
            dcache_pkg::lhu: return {16'h0, sh[15:0]};
            dcache_pkg::lb:  return {{24{sh[7]}}, sh[7:0]};
            dcache_pkg::lbu: return {24'h0, sh[7:0]};
            default:         return w;
        endcase
    endfunction

    task automatic idle_cycles(int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic pick_request();
        int kind;
        logic [31:0] a;
        kind = $urandom_range(0, 7);
        req_valid = (kind != 0);
        req_write = (kind >= 5);
        load_type = dcache_pkg::load_type_e'($urandom_range(0, 4));
        if (!req_write && last_was_store && $urandom_range(0, 1) == 1)
            a = {last_store_addr[31:2], 2'($urandom_range(0, 3))}; // reload the stored word
        else
            a = make_addr($urandom_range(0, 7), $urandom_range(0, 15), $urandom_range(0, 15));
        if (req_write || load_type == dcache_pkg::lw) a[1:0] = 2'b00;
        else if (load_type == dcache_pkg::lh || load_type == dcache_pkg::lhu) a[0] = 1'b0;
        req_addr.raw = a;
        req_wstrb    = 4'($urandom_range(0, 15));
        req_wdata    = $urandom();
        cur_valid    = req_valid;
        cur_write    = req_write;
        cur_addr     = a;
        cur_lt       = load_type;
        if (req_valid && req_write) begin
            for (int b = 0; b < 4; b++)
                if (req_wstrb[b]) golden[word_slot(a)][8*b +: 8] = req_wdata[8*b +: 8];
            last_store_addr = a;
            store_count++;
        end else if (req_valid) begin
            load_count++;
        end
        last_was_store = req_valid && req_write;
    endtask

    task automatic check_result();
        logic [31:0] exp;
        if (!cur_valid) begin
            check_count++;
            assert (rdata == 32'h0) else begin
                err_count++;
                $display("ERROR rdata idle: got %h expected %h", rdata, 32'h0);
            end
        end else if (!cur_write) begin
            check_count++;
            exp = expect_load(golden[word_slot(cur_addr)], cur_lt, cur_addr[1:0]);
            assert (rdata == exp) else begin
                err_count++;
                $display("ERROR rdata at %h type %s: got %h expected %h",
                         cur_addr, cur_lt.name(), rdata, exp);
            end
        end
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin : stimulus
        int issued;
        void'($urandom(33));
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_wstrb = 4'h0;
        req_wdata = 32'h0;
        load_type = dcache_pkg::lw;
        cur_valid = 1'b0;
        last_was_store = 1'b0;
        for (int s = 0; s < 512; s++) begin
            golden[s]  = fill_word({tag_base[23:3], 9'(s), 2'b00});
            backing[s] = golden[s];
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_count++;
        assert (!busy && !rd_req && !wr_req) else begin
            err_count++;
            $display("ERROR after reset: busy %h rd_req %h wr_req %h", busy, rd_req, wr_req);
        end
        pick_request();
        issued = 1;
        while (issued < n_req) begin
            @(negedge clk);
            if (!busy) begin
                check_result();
                pick_request();
                issued++;
            end
        end
        @(negedge clk);
        while (busy) @(negedge clk);
        check_result();
        req_valid = 1'b0;
        $display("checks %0d errors %0d loads %0d stores %0d",
                 check_count, err_count, load_count, store_count);
        if (err_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial begin : responder
        logic [31:0] wb_addr;
        dcache_pkg::line_t wb_line;
        rd_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_data = '0;
        wr_rdy = 1'b0;
        wr_valid = 1'b0;
        forever begin
            @(negedge clk);
            if (wr_req) begin
                wb_addr = wr_addr;
                wb_line = wr_data;
                check_count++;
                assert (wb_addr[3:0] == 4'h0
                        && wb_line == read_line(golden, wb_addr)) else begin
                    err_count++;
                    $display("ERROR wr_data at %h: got %h expected %h",
                             wb_addr, wb_line, read_line(golden, wb_addr));
                end
                idle_cycles($urandom_range(0, 3));
                wr_rdy = 1'b1;
                @(negedge clk);
                wr_rdy = 1'b0;
                idle_cycles($urandom_range(0, 3));
                for (int w = 0; w < 4; w++) backing[word_slot(wb_addr) + w] = wb_line[w];
                wr_valid = 1'b1;
                @(negedge clk);
                wr_valid = 1'b0;
            end else if (rd_req) begin
                check_count++;
                assert (rd_addr == {cur_addr[31:4], 4'h0}) else begin
                    err_count++;
                    $display("ERROR rd_addr: got %h expected %h",
                             rd_addr, {cur_addr[31:4], 4'h0});
                end
                idle_cycles($urandom_range(0, 3));
                rd_rdy = 1'b1;
                @(negedge clk);
                rd_rdy = 1'b0;
                idle_cycles($urandom_range(0, 3));
                ret_data  = read_line(backing, rd_addr);
                ret_valid = 1'b1;
                @(negedge clk);
                ret_valid = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("timeout: requests still pending after %0d ns, errors %0d",
                 timeout_ns, err_count);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- dcache_asserts.sv
/* dcache controller protocol checks
   memory request exclusivity, request hold until ready, idle busy */
`timescale 1ns/1ps
module dcache_asserts (
    input logic       clk,
    input logic       rst_n,
    input logic       busy,
    input logic       req_valid,
    input logic       rd_req,
    input logic       rd_rdy,
    input logic       wr_req,
    input logic       wr_rdy,
    input logic [2:0] state
);

    one_request: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_req && wr_req))
        else $error("rd_req and wr_req high together");

    rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req && !rd_rdy |=> rd_req)
        else $error("rd_req dropped before rd_rdy");

    wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wr_req && !wr_rdy |=> wr_req)
        else $error("wr_req dropped before wr_rdy");

    // a free cycle with no request leaves the cache idle in lookup
    idle_free: assert property (@(posedge clk) disable iff (!rst_n)
        !busy && !req_valid |=> state == dcache_pkg::st_lookup && !busy)
        else $error("cache busy after a free cycle with no request");

endmodule

//--- dcache_top.sv
/* dcache top
   4-way write-back data cache, controller + arrays + plru + load/store datapath */
`timescale 1ns/1ps
module dcache_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  logic                   req_write,
    input  dcache_pkg::addr_u      req_addr,
    input  logic [3:0]             req_wstrb,
    input  logic [31:0]            req_wdata,
    input  dcache_pkg::load_type_e load_type,
    output logic                   busy,
    output logic [31:0]            rdata,
    output logic                   rd_req,
    output logic [31:0]            rd_addr,
    input  logic                   rd_rdy,
    input  logic                   ret_valid,
    input  dcache_pkg::line_t      ret_data,
    output logic                   wr_req,
    output logic [31:0]            wr_addr,
    output dcache_pkg::line_t      wr_data,
    input  logic                   wr_rdy,
    input  logic                   wr_valid
);
    logic [dcache_pkg::way_num-1:0][dcache_pkg::tag_w-1:0] tag_rd;
    logic [dcache_pkg::way_num-1:0]    valid_rd;
    logic [dcache_pkg::way_num-1:0]    dirty_rd;
    dcache_pkg::line_t [dcache_pkg::way_num-1:0] line_rd;
    logic [dcache_pkg::way_w-1:0]      victim_way;
    logic                              buf_valid;
    logic                              buf_write;
    dcache_pkg::addr_u                 buf_addr;
    logic [3:0]                        buf_wstrb;
    logic [31:0]                       buf_wdata;
    dcache_pkg::load_type_e            buf_load_type;
    logic [dcache_pkg::index_w-1:0]    rd_index;
    logic [dcache_pkg::way_num-1:0]    hit;
    logic                              plru_update;
    logic [dcache_pkg::way_num-1:0]    refill_we;
    dcache_pkg::line_t                 refill_line;
    logic [dcache_pkg::way_num-1:0]    store_we;
    logic [dcache_pkg::index_w-1:0]    store_index;
    dcache_pkg::line_t                 store_line;

    dcache_ctrl i_ctrl (
        .clk, .rst_n,
        .req_valid, .req_write, .req_addr, .req_wstrb, .req_wdata, .load_type,
        .rd_rdy, .ret_valid, .ret_data, .wr_rdy, .wr_valid,
        .tag_rd, .valid_rd, .dirty_rd, .victim_way,
        .busy, .buf_valid, .buf_write, .buf_addr, .buf_wstrb, .buf_wdata, .buf_load_type,
        .rd_index, .hit, .plru_update, .refill_we, .refill_line,
        .rd_req, .rd_addr, .wr_req, .wr_addr
    );

    dcache_arrays i_arrays (
        .clk, .rst_n, .rd_index,
        .refill_we,
        .refill_index (buf_addr.f.index),
        .refill_line,
        .refill_tag   (buf_addr.f.tag),
        .store_we, .store_index, .store_line,
        .tag_rd, .valid_rd, .dirty_rd, .line_rd
    );

    dcache_plru i_plru (
        .clk, .rst_n,
        .index      (buf_addr.f.index),
        .hit,
        .update     (plru_update),
        .victim_way
    );

    dcache_datapath i_datapath (
        .clk, .rst_n, .line_rd, .hit,
        .buf_valid, .buf_write, .buf_addr, .buf_wstrb, .buf_wdata, .buf_load_type,
        .rdata, .store_we, .store_index, .store_line, .wr_data
    );

endmodule

//--- dcache_ctrl.sv
/* dcache controller
   request buffer, tag compare and the miss / write-back / refill state machine */
`timescale 1ns/1ps
module dcache_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  logic                   req_write,
    input  dcache_pkg::addr_u      req_addr,
    input  logic [3:0]             req_wstrb,
    input  logic [31:0]            req_wdata,
    input  dcache_pkg::load_type_e load_type,
    input  logic                   rd_rdy,
    input  logic                   ret_valid,
    input  dcache_pkg::line_t      ret_data,
    input  logic                   wr_rdy,
    input  logic                   wr_valid,
    input  logic [dcache_pkg::way_num-1:0][dcache_pkg::tag_w-1:0] tag_rd,
    input  logic [dcache_pkg::way_num-1:0] valid_rd,
    input  logic [dcache_pkg::way_num-1:0] dirty_rd,
    input  logic [dcache_pkg::way_w-1:0]   victim_way,
    output logic                   busy,
    output logic                   buf_valid,
    output logic                   buf_write,
    output dcache_pkg::addr_u      buf_addr,
    output logic [3:0]             buf_wstrb,
    output logic [31:0]            buf_wdata,
    output dcache_pkg::load_type_e buf_load_type,
    output logic [dcache_pkg::index_w-1:0] rd_index,
    output logic [dcache_pkg::way_num-1:0] hit,
    output logic                   plru_update,
    output logic [dcache_pkg::way_num-1:0] refill_we,
    output dcache_pkg::line_t      refill_line,
    output logic                   rd_req,
    output logic [31:0]            rd_addr,
    output logic                   wr_req,
    output logic [31:0]            wr_addr
);
    logic [2:0]                     state;
    logic [2:0]                     state_nxt;
    logic                           req_v;
    logic [dcache_pkg::way_num-1:0] hit_cmp;
    logic [dcache_pkg::way_num-1:0] victim_oh;
    logic                           hit_any;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_v <= 1'b0;
            state <= dcache_pkg::st_lookup;
        end else begin
            if (!busy) req_v <= req_valid;
            state <= state_nxt;
        end
    end

    // request payload, held while busy
    always_ff @(posedge clk) begin
        if (!busy) begin
            buf_write     <= req_write;
            buf_addr      <= req_addr;
            buf_wstrb     <= req_wstrb;
            buf_wdata     <= req_wdata;
            buf_load_type <= load_type;
        end
    end

    always_comb begin
        for (int w = 0; w < dcache_pkg::way_num; w++) begin
            hit_cmp[w] = valid_rd[w] && (tag_rd[w] == buf_addr.f.tag);
        end
        victim_oh             = '0;
        victim_oh[victim_way] = 1'b1;
    end

    assign hit_any     = |hit_cmp;
    assign busy        = (state != dcache_pkg::st_lookup) || (req_v && !hit_any);
    assign buf_valid   = req_v && (state == dcache_pkg::st_lookup); // only a lookup is live
    assign hit         = (state == dcache_pkg::st_lookup) ? hit_cmp : victim_oh;
    assign plru_update = buf_valid && hit_any;
    assign rd_index    = busy ? buf_addr.f.index : req_addr.f.index;

    assign refill_we   = (state == dcache_pkg::st_refill && ret_valid) ? victim_oh : '0;
    assign refill_line = ret_data;

    assign rd_req  = (state == dcache_pkg::st_miss_clean);
    assign wr_req  = (state == dcache_pkg::st_miss_dirty);
    assign rd_addr = {buf_addr.f.tag, buf_addr.f.index, {dcache_pkg::offset_w{1'b0}}};
    assign wr_addr = {tag_rd[victim_way], buf_addr.f.index, {dcache_pkg::offset_w{1'b0}}};

    always_comb begin
        state_nxt = state;
        case (state)
            dcache_pkg::st_lookup: begin
                if (req_v && !hit_any) begin
                    state_nxt = dirty_rd[victim_way] ? dcache_pkg::st_miss_dirty
                                                     : dcache_pkg::st_miss_clean;
                end
            end
            dcache_pkg::st_miss_dirty: begin
                if (wr_rdy) state_nxt = dcache_pkg::st_writeback;
            end
            dcache_pkg::st_writeback: begin
                if (wr_valid) state_nxt = dcache_pkg::st_miss_clean; // victim is out
            end
            dcache_pkg::st_miss_clean: begin
                if (rd_rdy) state_nxt = dcache_pkg::st_refill;
            end
            dcache_pkg::st_refill: begin
                if (ret_valid) state_nxt = dcache_pkg::st_refill_done;
            end
            default: state_nxt = dcache_pkg::st_lookup; // refill done, look up again
        endcase
    end

endmodule

//--- dcache_datapath.sv
/* dcache load/store datapath
   way and word select, load extension, strobe merge into the store buffer */
`timescale 1ns/1ps
module dcache_datapath (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  dcache_pkg::line_t [dcache_pkg::way_num-1:0] line_rd,
    input  logic [dcache_pkg::way_num-1:0]       hit,
    input  logic                                 buf_valid,
    input  logic                                 buf_write,
    input  dcache_pkg::addr_u                    buf_addr,
    input  logic [3:0]                           buf_wstrb,
    input  logic [31:0]                          buf_wdata,
    input  dcache_pkg::load_type_e               buf_load_type,
    output logic [31:0]                          rdata,
    output logic [dcache_pkg::way_num-1:0]       store_we,
    output logic [dcache_pkg::index_w-1:0]       store_index,
    output dcache_pkg::line_t                    store_line,
    output dcache_pkg::line_t                    wr_data
);
    dcache_pkg::line_t sel_line;
    dcache_pkg::line_t merged;
    logic [31:0]       word;
    logic [15:0]       half;
    logic [7:0]        byte_v;
    logic [31:0]       ext;

    always_comb begin
        sel_line = '0;
        for (int w = 0; w < dcache_pkg::way_num; w++) begin
            if (hit[w]) sel_line = sel_line | line_rd[w];
        end
    end

    assign word    = sel_line[buf_addr.f.offset[3:2]];
    assign half    = buf_addr.f.offset[1] ? word[31:16] : word[15:0];
    assign byte_v  = word[8*buf_addr.f.offset[1:0] +: 8];
    assign wr_data = sel_line; // victim line in miss states

    always_comb begin
        case (buf_load_type)
            dcache_pkg::lh:  ext = {{16{half[15]}}, half};
            dcache_pkg::lhu: ext = {16'b0, half};
            dcache_pkg::lb:  ext = {{24{byte_v[7]}}, byte_v};
            dcache_pkg::lbu: ext = {24'b0, byte_v};
            default:         ext = word;
        endcase
    end

    assign rdata = buf_valid ? ext : 32'b0;

    always_comb begin
        merged = sel_line;
        for (int b = 0; b < 4; b++) begin
            if (buf_wstrb[b]) merged[buf_addr.f.offset[3:2]][8*b +: 8] = buf_wdata[8*b +: 8];
        end
    end

    // store buffer, commits next cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) store_we <= '0;
        else store_we <= (buf_valid && buf_write) ? hit : '0;
    end

    always_ff @(posedge clk) begin
        store_index <= buf_addr.f.index;
        store_line  <= merged;
    end

endmodule

//--- dcache_plru.sv
/* dcache replacement
   3-bit tree pseudo-LRU per set, victim lookup and update on hit */
`timescale 1ns/1ps
module dcache_plru (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [dcache_pkg::index_w-1:0] index,
    input  logic [dcache_pkg::way_num-1:0] hit,
    input  logic                           update,
    output logic [dcache_pkg::way_w-1:0]   victim_way
);
    logic [dcache_pkg::set_num-1:0][2:0] tree;
    logic [2:0]                          bits;
    logic [dcache_pkg::way_w-1:0]        hit_way;

    assign bits    = tree[index];
    assign hit_way = {hit[3] | hit[2], hit[3] | hit[1]}; // one-hot to binary

    // bit0 picks the half, bit1 / bit2 the way within it
    assign victim_way = bits[0] ? {1'b1, bits[2]} : {1'b0, bits[1]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tree <= '0;
        end else if (update) begin
            tree[index][0] <= ~hit_way[1];
            if (hit_way[1]) tree[index][2] <= ~hit_way[0];
            else tree[index][1] <= ~hit_way[0];
        end
    end

endmodule

//--- dcache_arrays.sv
/* dcache storage arrays
   per-way valid, tag, dirty and line, registered write-first reads */
`timescale 1ns/1ps
module dcache_arrays (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [dcache_pkg::index_w-1:0]    rd_index,
    input  logic [dcache_pkg::way_num-1:0]    refill_we,
    input  logic [dcache_pkg::index_w-1:0]    refill_index,
    input  dcache_pkg::line_t                 refill_line,
    input  logic [dcache_pkg::tag_w-1:0]      refill_tag,
    input  logic [dcache_pkg::way_num-1:0]    store_we,
    input  logic [dcache_pkg::index_w-1:0]    store_index,
    input  dcache_pkg::line_t                 store_line,
    output logic [dcache_pkg::way_num-1:0][dcache_pkg::tag_w-1:0] tag_rd,
    output logic [dcache_pkg::way_num-1:0]    valid_rd,
    output logic [dcache_pkg::way_num-1:0]    dirty_rd,
    output dcache_pkg::line_t [dcache_pkg::way_num-1:0] line_rd
);
    logic [dcache_pkg::way_num-1:0][dcache_pkg::set_num-1:0] valid_bits;
    logic [dcache_pkg::way_num-1:0][dcache_pkg::set_num-1:0] dirty_bits;
    logic [dcache_pkg::tag_w-1:0] tag_mem  [dcache_pkg::way_num][dcache_pkg::set_num];
    dcache_pkg::line_t            line_mem [dcache_pkg::way_num][dcache_pkg::set_num];
    logic [dcache_pkg::way_num-1:0]    dirty_q;
    dcache_pkg::line_t [dcache_pkg::way_num-1:0] line_q;
    logic [dcache_pkg::index_w-1:0]    rd_index_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            valid_rd   <= '0;
            dirty_q    <= '0;
        end else begin
            for (int w = 0; w < dcache_pkg::way_num; w++) begin
                valid_rd[w] <= valid_bits[w][rd_index]
                               | (refill_we[w] && refill_index == rd_index);
                if (refill_we[w] && refill_index == rd_index) dirty_q[w] <= 1'b0;
                else if (store_we[w] && store_index == rd_index) dirty_q[w] <= 1'b1;
                else dirty_q[w] <= dirty_bits[w][rd_index];
                if (refill_we[w]) begin
                    valid_bits[w][refill_index] <= 1'b1;
                    dirty_bits[w][refill_index] <= 1'b0; // fresh line is clean
                end
                if (store_we[w]) dirty_bits[w][store_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_index_q <= rd_index;
        for (int w = 0; w < dcache_pkg::way_num; w++) begin
            tag_rd[w] <= (refill_we[w] && refill_index == rd_index) ? refill_tag
                                                                    : tag_mem[w][rd_index];
            if (refill_we[w] && refill_index == rd_index) line_q[w] <= refill_line;
            else if (store_we[w] && store_index == rd_index) line_q[w] <= store_line;
            else line_q[w] <= line_mem[w][rd_index];
            if (refill_we[w]) begin
                tag_mem[w][refill_index]  <= refill_tag;
                line_mem[w][refill_index] <= refill_line;
            end
            if (store_we[w]) line_mem[w][store_index] <= store_line;
        end
    end

    // pending store buffer shows through on the read side
    always_comb begin
        for (int w = 0; w < dcache_pkg::way_num; w++) begin
            dirty_rd[w] = dirty_q[w] | (store_we[w] && store_index == rd_index_q);
            line_rd[w]  = (store_we[w] && store_index == rd_index_q) ? store_line : line_q[w];
        end
    end

endmodule

//--- dcache_pkg.sv
/* dcache package
   cache geometry, address layout, load types and controller state codes */
package dcache_pkg;

    localparam int way_num    = 4;
    localparam int line_words = 4;
    localparam int set_num    = 16;
    localparam int offset_w   = 4;
    localparam int index_w    = 4;
    localparam int tag_w      = 24;
    localparam int way_w      = 2;

    // controller states
    localparam logic [2:0] st_lookup      = 3'd0;
    localparam logic [2:0] st_miss_dirty  = 3'd1;
    localparam logic [2:0] st_writeback   = 3'd2;
    localparam logic [2:0] st_miss_clean  = 3'd3;
    localparam logic [2:0] st_refill      = 3'd4;
    localparam logic [2:0] st_refill_done = 3'd5;

    typedef logic [line_words-1:0][31:0] line_t;

    // same word seen as a bus address or as cache fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [tag_w-1:0]    tag;
            logic [index_w-1:0]  index;
            logic [offset_w-1:0] offset;
        } f;
    } addr_u;

    typedef enum logic [2:0] {
        lw,
        lh,
        lhu,
        lb,
        lbu
    } load_type_e;

endpackage
